// File: hdl/byteRam.sv
module byteRam #(
    parameter int addrBits = memPkg::memAddrBits
) (
    input  logic                clk,
    input  logic [addrBits-1:0] addr,
    input  logic                we,
    input  memPkg::byteT        wdata,
    output memPkg::byteT        rdata
);

    localparam int depth = 2 ** addrBits;

    memPkg::byteT mem [depth];

    // read returns the old byte on a same-cycle write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: hdl/fetchUnit.sv
module fetchUnit #(
    parameter memPkg::addrT resetPc = '0
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         enable,
    input  logic         restart,
    input  logic         instDone,
    input  memPkg::wordT instRdata,
    output logic         instReq,
    output memPkg::addrT instAddr,
    output logic         instValid,
    output memPkg::wordT instWord,
    output memPkg::addrT instPc
);

    memPkg::addrT pc;
    logic         restartPending;

    assign instAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            instReq        <= 1'b0;
            pc             <= resetPc;
            restartPending <= 1'b0;
            instValid      <= 1'b0;
        end else begin
            instValid <= instDone;
            if (instReq) begin
                if (instDone) begin
                    instReq        <= enable;
                    restartPending <= 1'b0;
                    pc             <= (restart || restartPending) ? resetPc : pc + 32'd4;
                end else if (restart) begin
                    // wait for the outstanding fetch
                    restartPending <= 1'b1;
                end
            end else begin
                instReq <= enable;
                if (restart) begin
                    pc <= resetPc;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instDone) begin
            instWord <= instRdata;
            instPc   <= pc;
        end
    end

    addrHeld: assert property (@(posedge clk) disable iff (rst)
        instReq && !instDone |=> instReq && $stable(instAddr));

endmodule

// File: hdl/loadStoreUnit.sv
module loadStoreUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           cmdValid,
    input  logic           cmdStore,
    input  memPkg::funct3T cmdFunct3,
    input  memPkg::addrT   cmdAddr,
    input  memPkg::wordT   cmdWdata,
    input  logic           dataDone,
    input  memPkg::wordT   dataRdata,
    output logic           dataReq,
    output logic           dataWrite,
    output memPkg::lenT    dataLen,
    output memPkg::addrT   dataAddr,
    output memPkg::wordT   dataWdata,
    output logic           busy,
    output logic           done,
    output memPkg::wordT   rdata
);

    memPkg::funct3T funct3Reg;
    memPkg::lenT    cmdLen;

    // width from the low funct3 bits
    always_comb begin
        case (cmdFunct3[1:0])
            2'b00:   cmdLen = memPkg::lenByte;
            2'b01:   cmdLen = memPkg::lenHalf;
            default: cmdLen = memPkg::lenWord;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dataReq <= 1'b0;
        end else if (dataReq) begin
            if (dataDone) begin
                dataReq <= 1'b0;
            end
        end else if (cmdValid) begin
            dataReq <= 1'b1;
        end
    end

    // commands while busy are dropped
    always_ff @(posedge clk) begin
        if (!dataReq && cmdValid) begin
            dataWrite <= cmdStore;
            funct3Reg <= cmdFunct3;
            dataLen   <= cmdLen;
            dataAddr  <= cmdAddr;
            dataWdata <= cmdWdata;
        end
    end

    assign busy = dataReq;
    assign done = dataDone;

    always_comb begin
        case (funct3Reg)
            memPkg::fnB:  rdata = {{24{dataRdata[7]}}, dataRdata[7:0]};
            memPkg::fnH:  rdata = {{16{dataRdata[15]}}, dataRdata[15:0]};
            memPkg::fnBU: rdata = {24'd0, dataRdata[7:0]};
            memPkg::fnHU: rdata = {16'd0, dataRdata[15:0]};
            default:      rdata = dataRdata;
        endcase
    end

    reqDropsAfterDone: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataReq);

endmodule

// File: hdl/memCtrl.sv
module memCtrl #(
    parameter int addrBits = memPkg::memAddrBits
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                dataReq,
    input  logic                dataWrite,
    input  memPkg::lenT         dataLen,
    input  memPkg::addrT        dataAddr,
    input  memPkg::wordT        dataWdata,
    input  logic                instReq,
    input  memPkg::addrT        instAddr,
    input  memPkg::byteT        ramRdata,
    output logic                dataDone,
    output memPkg::wordT        dataRdata,
    output logic                instDone,
    output memPkg::wordT        instRdata,
    output logic [addrBits-1:0] ramAddr,
    output logic                ramWe,
    output memPkg::byteT        ramWdata
);

    memPkg::ctrlStateT state;
    memPkg::ctrlStateT opState;
    logic [2:0]        byteCnt;
    logic [2:0]        addrIdx;
    logic [1:0]        capIdx;

    // latched access
    memPkg::addrT baseAddr;
    memPkg::lenT  accLen;
    memPkg::wordT wrData;
    memPkg::wordT asmData;

    memPkg::addrT curBase;
    memPkg::lenT  curLen;
    memPkg::wordT curWdata;
    memPkg::addrT byteAddr;
    memPkg::wordT readWord;
    logic         readEnd;

    // in idle the request being accepted is served at once
    always_comb begin
        opState  = state;
        curBase  = baseAddr;
        curLen   = accLen;
        curWdata = wrData;
        if (state == memPkg::idle) begin
            curWdata = dataWdata;
            if (dataReq) begin
                opState = dataWrite ? memPkg::writeData : memPkg::readData;
                curBase = dataAddr;
                curLen  = dataLen;
            end else if (instReq) begin
                opState = memPkg::readInst;
                curBase = instAddr;
                curLen  = memPkg::lenWord;
            end
        end
    end

    // a stalled read keeps the previous byte on the RAM output
    always_comb begin
        if (state == memPkg::idle) begin
            addrIdx = 3'd0;
        end else if (stall && state != memPkg::writeData) begin
            addrIdx = byteCnt - 3'd1;
        end else begin
            addrIdx = byteCnt;
        end
    end

    assign byteAddr = curBase + memPkg::addrT'(addrIdx);
    assign ramAddr  = byteAddr[addrBits-1:0];
    assign ramWdata = curWdata[{addrIdx[1:0], 3'b000} +: 8];
    assign ramWe    = !stall && opState == memPkg::writeData;

    assign capIdx  = byteCnt[1:0] - 2'd1;
    assign readEnd = byteCnt == {1'b0, accLen} + 3'd1;

    // last byte joins the word as it comes back
    always_comb begin
        readWord = asmData;
        readWord[{accLen, 3'b000} +: 8] = ramRdata;
    end

    assign dataRdata = readWord;
    assign instRdata = readWord;

    assign dataDone = !stall && (
        (opState == memPkg::writeData && addrIdx[1:0] == curLen) ||
        (state == memPkg::readData && readEnd));
    assign instDone = !stall && state == memPkg::readInst && readEnd;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= memPkg::idle;
            byteCnt <= 3'd0;
        end else if (!stall) begin
            case (state)
                memPkg::idle: begin
                    if (opState != memPkg::idle) begin
                        byteCnt <= 3'd1;
                        // single byte write finishes in the accept cycle
                        if (!(opState == memPkg::writeData && curLen == memPkg::lenByte)) begin
                            state <= opState;
                        end
                    end
                end
                memPkg::readInst, memPkg::readData: begin
                    if (readEnd) begin
                        state   <= memPkg::idle;
                        byteCnt <= 3'd0;
                    end else begin
                        byteCnt <= byteCnt + 3'd1;
                    end
                end
                memPkg::writeData: begin
                    if (byteCnt[1:0] == accLen) begin
                        state   <= memPkg::idle;
                        byteCnt <= 3'd0;
                    end else begin
                        byteCnt <= byteCnt + 3'd1;
                    end
                end
                default: begin
                    state <= memPkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == memPkg::idle) begin
                baseAddr <= curBase;
                accLen   <= curLen;
                wrData   <= curWdata;
                asmData  <= '0;
            end else if (state != memPkg::writeData) begin
                asmData[{capIdx, 3'b000} +: 8] <= ramRdata;
            end
        end
    end

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(dataDone && instDone));

    // writes only belong to a held data write request
    weOnlyInWrite: assert property (@(posedge clk) disable iff (rst)
        ramWe |-> dataReq && dataWrite);

    stallFreezes: assert property (@(posedge clk) disable iff (rst)
        stall |-> !ramWe ##1 ($stable(state) && $stable(byteCnt)));

endmodule

// File: hdl/memPkg.sv
package memPkg;

    // default RAM depth as address bits
    parameter int memAddrBits = 12;

    typedef logic [31:0] addrT;
    typedef logic [7:0]  byteT;
    typedef logic [31:0] wordT;

    // access length minus one
    typedef logic [1:0] lenT;

    // RV32 load/store width code
    typedef logic [2:0] funct3T;

    localparam funct3T fnB  = 3'b000;
    localparam funct3T fnH  = 3'b001;
    localparam funct3T fnW  = 3'b010;
    localparam funct3T fnBU = 3'b100;
    localparam funct3T fnHU = 3'b101;

    localparam lenT lenByte = 2'd0;
    localparam lenT lenHalf = 2'd1;
    localparam lenT lenWord = 2'd3;

    typedef enum logic [1:0] {
        idle,
        readInst,
        readData,
        writeData
    } ctrlStateT;

endpackage

// File: hdl/memSubsystem.sv
module memSubsystem #(
    parameter int           addrBits = memPkg::memAddrBits,
    parameter memPkg::addrT resetPc  = '0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           cmdValid,
    input  logic           cmdStore,
    input  memPkg::funct3T cmdFunct3,
    input  memPkg::addrT   cmdAddr,
    input  memPkg::wordT   cmdWdata,
    input  logic           fetchEnable,
    input  logic           fetchRestart,
    output logic           lsuBusy,
    output logic           lsuDone,
    output memPkg::wordT   lsuRdata,
    output logic           instValid,
    output memPkg::wordT   instWord,
    output memPkg::addrT   instPc
);

    logic         dataReq;
    logic         dataWrite;
    memPkg::lenT  dataLen;
    memPkg::addrT dataAddr;
    memPkg::wordT dataWdata;
    logic         dataDone;
    memPkg::wordT dataRdata;

    logic         instReq;
    memPkg::addrT instAddr;
    logic         instDone;
    memPkg::wordT instRdata;

    logic [addrBits-1:0] ramAddr;
    logic                ramWe;
    memPkg::byteT        ramWdata;
    memPkg::byteT        ramRdata;

    fetchUnit #(
        .resetPc(resetPc)
    ) fetch (
        .clk(clk),
        .rst(rst),
        .enable(fetchEnable),
        .restart(fetchRestart),
        .instDone(instDone),
        .instRdata(instRdata),
        .instReq(instReq),
        .instAddr(instAddr),
        .instValid(instValid),
        .instWord(instWord),
        .instPc(instPc)
    );

    loadStoreUnit lsu (
        .clk(clk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdStore(cmdStore),
        .cmdFunct3(cmdFunct3),
        .cmdAddr(cmdAddr),
        .cmdWdata(cmdWdata),
        .dataDone(dataDone),
        .dataRdata(dataRdata),
        .dataReq(dataReq),
        .dataWrite(dataWrite),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .busy(lsuBusy),
        .done(lsuDone),
        .rdata(lsuRdata)
    );

    memCtrl #(
        .addrBits(addrBits)
    ) ctrl (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .dataReq(dataReq),
        .dataWrite(dataWrite),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .instReq(instReq),
        .instAddr(instAddr),
        .ramRdata(ramRdata),
        .dataDone(dataDone),
        .dataRdata(dataRdata),
        .instDone(instDone),
        .instRdata(instRdata),
        .ramAddr(ramAddr),
        .ramWe(ramWe),
        .ramWdata(ramWdata)
    );

    byteRam #(
        .addrBits(addrBits)
    ) ram (
        .clk(clk),
        .addr(ramAddr),
        .we(ramWe),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

endmodule

// File: memSubsystem.f
hdl/memPkg.sv
hdl/byteRam.sv
hdl/memCtrl.sv
hdl/fetchUnit.sv
hdl/loadStoreUnit.sv
hdl/memSubsystem.sv
verification/memSubsystemTb.sv

// File: run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module memSubsystemTb -f memSubsystem.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VmemSubsystemTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
exit 0

// File: verification/memSubsystemTb.sv
module memSubsystemTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int addrBits = 12;
    localparam memPkg::addrT resetPc = 32'h0000_0100;
    localparam int cycleLimit = 4000;

    logic           clk = 1'b0;
    logic           rst;
    logic           stall;
    logic           cmdValid;
    logic           cmdStore;
    memPkg::funct3T cmdFunct3;
    memPkg::addrT   cmdAddr;
    memPkg::wordT   cmdWdata;
    logic           fetchEnable;
    logic           fetchRestart;
    logic           lsuBusy;
    logic           lsuDone;
    memPkg::wordT   lsuRdata;
    logic           instValid;
    memPkg::wordT   instWord;
    memPkg::addrT   instPc;

    // reference bytes with data at 0x000..0x0ff and code at 0x100..0x1ff
    memPkg::byteT refMem [512];
    logic [31:0]  rngState = 32'd28;
    memPkg::addrT expPc;
    memPkg::wordT expInstWord;
    memPkg::wordT expRdata;
    logic         expLoad = 1'b0;
    logic [7:0]   expLat = 8'd0;
    logic         latencyOn = 1'b0;
    logic [7:0]   latCnt;
    logic         rstPrev;
    logic         stallPrev;
    int           cycleCount = 0;
    int           errorCount = 0;
    int           testErrors = 0;
    int           passCount = 0;
    int           failCount = 0;

    memSubsystem #(
        .addrBits(addrBits),
        .resetPc(resetPc)
    ) dut_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        rstPrev   <= rst;
        stallPrev <= stall;
        if (rst || fetchRestart) begin
            expPc <= resetPc;
        end else if (instValid) begin
            expPc <= expPc + 32'd4;
        end
        // cycles since the command strobe
        if (rst || lsuDone) begin
            latCnt <= 8'd0;
        end else if (cmdValid && !lsuBusy) begin
            latCnt <= 8'd1;
        end else if (latCnt != 8'd0) begin
            latCnt <= latCnt + 8'd1;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    assign expInstWord = {refMem[expPc[8:0] + 9'd3], refMem[expPc[8:0] + 9'd2],
                          refMem[expPc[8:0] + 9'd1], refMem[expPc[8:0]]};

    afterReset: assert property (@(posedge clk)
        rstPrev && !rst |-> !instValid && !lsuDone && !lsuBusy)
        else begin
            errorCount++;
            $display("Error at %0t: outputs not idle after reset", $time);
        end

    loadData: assert property (@(posedge clk) disable iff (rst)
        lsuDone && expLoad |-> lsuRdata == expRdata)
        else begin
            errorCount++;
            $display("Error at %0t: load returned %h, expected %h", $time,
                     $sampled(lsuRdata), $sampled(expRdata));
        end

    doneLatency: assert property (@(posedge clk) disable iff (rst)
        lsuDone && latencyOn |-> latCnt == expLat)
        else begin
            errorCount++;
            $display("Error at %0t: lsuDone after %0d cycles, expected %0d", $time,
                     $sampled(latCnt), $sampled(expLat));
        end

    donePending: assert property (@(posedge clk) disable iff (rst)
        lsuDone |-> latCnt != 8'd0)
        else begin
            errorCount++;
            $display("Error at %0t: lsuDone without an outstanding command", $time);
        end

    instData: assert property (@(posedge clk) disable iff (rst)
        instValid |-> instPc == expPc && instWord == expInstWord)
        else begin
            errorCount++;
            $display("Error at %0t: fetched %h at pc %h, expected %h at pc %h", $time,
                     $sampled(instWord), $sampled(instPc), $sampled(expInstWord),
                     $sampled(expPc));
        end

    stallNoDone: assert property (@(posedge clk) disable iff (rst)
        stall |-> !lsuDone)
        else begin
            errorCount++;
            $display("Error at %0t: lsuDone while stalled", $time);
        end

    // instValid trails instDone by one cycle
    stallNoFetch: assert property (@(posedge clk) disable iff (rst)
        stallPrev |-> !instValid)
        else begin
            errorCount++;
            $display("Error at %0t: instValid after a stalled cycle", $time);
        end

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic int accessBytes(memPkg::funct3T f3);
        if (f3 == memPkg::fnB || f3 == memPkg::fnBU) begin
            return 1;
        end else if (f3 == memPkg::fnH || f3 == memPkg::fnHU) begin
            return 2;
        end
        return 4;
    endfunction

    function automatic memPkg::funct3T pickLoad(logic [2:0] sel);
        case (sel)
            3'd0:    return memPkg::fnB;
            3'd1:    return memPkg::fnH;
            3'd3:    return memPkg::fnBU;
            3'd4:    return memPkg::fnHU;
            default: return memPkg::fnW;
        endcase
    endfunction

    // little endian with the low byte at the access address
    function automatic memPkg::wordT loadExpect(memPkg::funct3T f3, memPkg::addrT addr);
        memPkg::wordT raw;
        for (int k = 0; k < 4; k++) begin
            raw[8*k +: 8] = refMem[addr[8:0] + 9'(k)];
        end
        case (f3)
            memPkg::fnB:  return {{24{raw[7]}}, raw[7:0]};
            memPkg::fnH:  return {{16{raw[15]}}, raw[15:0]};
            memPkg::fnBU: return {24'd0, raw[7:0]};
            memPkg::fnHU: return {16'd0, raw[15:0]};
            default:      return raw;
        endcase
    endfunction

    function automatic void storeRef(memPkg::funct3T f3, memPkg::addrT addr,
                                     memPkg::wordT data);
        for (int k = 0; k < accessBytes(f3); k++) begin
            refMem[addr[8:0] + 9'(k)] = data[8*k +: 8];
        end
    endfunction

    task automatic issue(input logic store, input memPkg::funct3T f3,
                         input memPkg::addrT addr, input memPkg::wordT data);
        int n;
        n = accessBytes(f3);
        // the previous lsuDone is sampled at this edge
        @(posedge clk);
        expLoad = !store;
        expLat = store ? 8'(n) : 8'(n + 1);
        if (store) begin
            storeRef(f3, addr, data);
        end else begin
            expRdata = loadExpect(f3, addr);
        end
        cmdValid  <= 1'b1;
        cmdStore  <= store;
        cmdFunct3 <= f3;
        cmdAddr   <= addr;
        cmdWdata  <= data;
        @(posedge clk);
        cmdValid <= 1'b0;
    endtask

    task automatic waitDone();
        @(negedge clk);
        while (!lsuDone) begin
            @(negedge clk);
        end
    endtask

    task automatic runOp(input logic store, input memPkg::funct3T f3,
                         input memPkg::addrT addr, input memPkg::wordT data);
        issue(store, f3, addr, data);
        waitDone();
    endtask

    task automatic randomOp();
        logic [31:0]    r;
        memPkg::funct3T f3;
        r = nextRand();
        f3 = pickLoad(r[2:0]);
        // stores only know byte, half and word
        if (r[3]) begin
            f3 = {1'b0, f3[1:0]};
        end
        runOp(r[3], f3, {24'd0, r[15:8] % 8'd240}, nextRand());
    endtask

    task automatic startFetch();
        @(posedge clk);
        fetchRestart <= 1'b1;
        fetchEnable  <= 1'b1;
        @(posedge clk);
        fetchRestart <= 1'b0;
    endtask

    task automatic stopFetch();
        @(posedge clk);
        fetchEnable <= 1'b0;
        @(negedge clk);
        while (dut_i.instReq) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic waitInsts(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (instValid) begin
                seen++;
            end
        end
    endtask

    task automatic finishTest(input string name);
        @(negedge clk);
        if (errorCount == testErrors) begin
            passCount++;
            $display("test %s: passed", name);
        end else begin
            failCount++;
            $display("test %s: failed with %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    initial begin
        logic [31:0]    r;
        memPkg::addrT   addr;
        memPkg::funct3T f3;
        rst          <= 1'b1;
        stall        <= 1'b0;
        cmdValid     <= 1'b0;
        cmdStore     <= 1'b0;
        cmdFunct3    <= memPkg::fnW;
        cmdAddr      <= '0;
        cmdWdata     <= '0;
        fetchEnable  <= 1'b0;
        fetchRestart <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        finishTest("outputs idle after reset");

        // fill both regions with word stores
        latencyOn = 1'b1;
        for (int i = 0; i < 128; i++) begin
            runOp(1'b1, memPkg::fnW, 32'(i * 4), nextRand());
        end
        for (int i = 0; i < 8; i++) begin
            r = nextRand();
            addr = {24'd0, r[7:2], 2'b00};
            runOp(1'b1, memPkg::fnW, addr, nextRand());
            runOp(1'b0, memPkg::fnW, addr, '0);
        end
        finishTest("word store and load");

        for (int i = 0; i < 20; i++) begin
            r = nextRand();
            addr = {24'd0, r[15:8] % 8'd240};
            f3 = (r[1:0] == 2'd0) ? memPkg::fnB : (r[1:0] == 2'd1) ? memPkg::fnH : memPkg::fnW;
            runOp(1'b1, f3, addr, nextRand());
            runOp(1'b0, memPkg::fnW, addr, '0);
            runOp(1'b0, pickLoad(r[6:4]), addr, '0);
        end
        finishTest("byte and half access");

        latencyOn = 1'b0;
        startFetch();
        waitInsts(24);
        stopFetch();
        finishTest("sequential fetch");

        startFetch();
        for (int i = 0; i < 12; i++) begin
            randomOp();
        end
        waitInsts(4);
        stopFetch();
        finishTest("fetch with load and store");

        startFetch();
        for (int i = 0; i < 4; i++) begin
            r = nextRand();
            issue(r[0], memPkg::fnW, {24'd0, r[13:8], 2'b00}, nextRand());
            @(posedge clk);
            stall <= 1'b1;
            repeat (6) @(posedge clk);
            stall <= 1'b0;
            waitDone();
        end
        @(posedge clk);
        stall <= 1'b1;
        repeat (7) @(posedge clk);
        stall <= 1'b0;
        waitInsts(3);
        stopFetch();
        finishTest("stall");

        $display("tests passed %0d, failed %0d, assertion errors %0d",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
